//--- hdl/bilin_params.svh
`ifndef BILIN_PARAMS_SVH
`define BILIN_PARAMS_SVH

// Output pixels handled per group
`define BILIN_LANES 4

// Linear address into either image memory
`define BILIN_AW 19

// Image sizes and integer coordinates
`define BILIN_DIM_W 16

// Grey pixel
`define BILIN_PIX_W 8

// Fraction bits of a source coordinate
`define BILIN_FRAC_W 8

// One in Q0.8 for the complementary weight
`define BILIN_ONE_Q08 256

// Half an LSB of Q8.16 for round to nearest
`define BILIN_ROUND_Q016 32768

`endif

//--- hdl/bilin_pkg.sv
`default_nettype none

`include "bilin_params.svh"

package bilin_pkg;

  // Image dimension or coordinate
  typedef logic [`BILIN_DIM_W-1:0]    dim_t;
  // Q8.8 scale and inverse scale
  typedef logic [2*`BILIN_FRAC_W-1:0] scale_t;
  typedef logic [`BILIN_AW-1:0]       addr_t;
  typedef logic [`BILIN_PIX_W-1:0]    pix_t;
  // Q0.8 coordinate fraction
  typedef logic [`BILIN_FRAC_W-1:0]   frac_t;
  // Q0.16 corner weight, wide enough for 256 x 256
  typedef logic [2*`BILIN_FRAC_W+1:0] weight_t;
  // Q8.16 product or sum
  typedef logic [31:0]                acc_t;

  // Fetch unit walk
  typedef enum logic [2:0] {
    FETCH_IDLE,
    FETCH_SETUP,
    FETCH_ROW,
    FETCH_GROUP,
    FETCH_READ,
    FETCH_HANDOFF
  } fetch_state_t;

  // Everything one lane needs to blend one output pixel
  typedef struct packed {
    logic  lane_valid;
    dim_t  x;
    frac_t fx;
    frac_t fy;
    pix_t  p00;
    pix_t  p10;
    pix_t  p01;
    pix_t  p11;
  } lane_req_t;

endpackage

`default_nettype wire

//--- hdl/bilin_fetch.sv
`timescale 1ns/1ps
`default_nettype none

`include "bilin_params.svh"

module bilin_fetch (
  input  wire logic                clk,
  input  wire logic                rst_n,
  input  wire logic                i_start,
  input  wire bilin_pkg::dim_t     i_in_w,
  input  wire bilin_pkg::dim_t     i_in_h,
  input  wire bilin_pkg::scale_t   i_scale_q88,
  input  wire bilin_pkg::pix_t     i_in_rdata,
  input  wire logic                i_grp_ready,
  input  wire logic                i_walk_done,
  output logic                     o_busy,
  output bilin_pkg::dim_t          o_out_w,
  output bilin_pkg::dim_t          o_out_h,
  output bilin_pkg::addr_t         o_in_raddr,
  output logic                     o_grp_valid,
  output bilin_pkg::lane_req_t     o_lane_req [`BILIN_LANES],
  output bilin_pkg::dim_t          o_row
);

  // Source base and fraction packed as {base, frac}
  function automatic logic [`BILIN_DIM_W+`BILIN_FRAC_W-1:0] clamp_src(
    input bilin_pkg::dim_t   pos,
    input bilin_pkg::scale_t inv,
    input bilin_pkg::dim_t   size
  );
    logic [31:0]     prod;
    bilin_pkg::dim_t whole;
    // Q16.8 source position
    prod  = pos * inv;
    whole = prod[`BILIN_DIM_W+`BILIN_FRAC_W-1:`BILIN_FRAC_W];
    // Past the last pair of pixels so pin to the border
    if (whole >= size - 1'b1) begin
      return {size - 2'd2, {`BILIN_FRAC_W{1'b1}}};
    end
    return {whole, prod[`BILIN_FRAC_W-1:0]};
  endfunction

  bilin_pkg::fetch_state_t state;
  logic                    busy_r;
  logic                    start_ok;
  logic                    grp_xfer;
  bilin_pkg::scale_t       inv_scale;
  bilin_pkg::scale_t       inv_next;
  logic [31:0]             mul_w;
  logic [31:0]             mul_h;
  bilin_pkg::dim_t         oy;
  bilin_pkg::dim_t         gx;
  bilin_pkg::dim_t         lane_x [`BILIN_LANES];
  bilin_pkg::dim_t         xi_base [`BILIN_LANES];
  bilin_pkg::dim_t         yi_base;
  bilin_pkg::frac_t        fy_row;
  // Read index holds the corner in bits 3 to 2 and the lane in bits 1 to 0
  logic [4:0]              rd_cnt;
  logic [3:0]              cap_idx;
  logic                    rd_en;
  logic                    cap_en;
  bilin_pkg::dim_t         rd_y;
  bilin_pkg::dim_t         rd_x;
  logic [31:0]             raddr_full;

  // ----------------------------------------
  // Setup math and handshake
  // ----------------------------------------
  assign mul_w = i_in_w * i_scale_q88;
  assign mul_h = i_in_h * i_scale_q88;

  always_comb begin
    if (i_scale_q88 == '0) begin
      inv_next = '1;
    end else begin
      // 65536 is one in Q8.8 squared
      inv_next = bilin_pkg::scale_t'(32'd65536 / i_scale_q88);
    end
  end

  // Busy drops in the cycle of the writer's done pulse
  assign o_busy      = busy_r & ~i_walk_done;
  assign start_ok    = (state == bilin_pkg::FETCH_IDLE) && i_start && !o_busy;
  assign o_grp_valid = (state == bilin_pkg::FETCH_HANDOFF);
  assign grp_xfer    = o_grp_valid && i_grp_ready;
  assign o_row       = oy;

  always_comb begin
    for (int l = 0; l < `BILIN_LANES; l++) begin
      lane_x[l] = gx + bilin_pkg::dim_t'(l);
    end
  end

  // ----------------------------------------
  // Corner reads
  // ----------------------------------------
  assign rd_en   = (state == bilin_pkg::FETCH_READ) && !rd_cnt[4];
  // Data returns one cycle after its address
  assign cap_idx = rd_cnt[3:0] - 4'd1;

  always_comb begin
    // Odd corners step right, upper corners step down
    rd_y       = yi_base + bilin_pkg::dim_t'(rd_cnt[3]);
    rd_x       = xi_base[rd_cnt[1:0]] + bilin_pkg::dim_t'(rd_cnt[2]);
    raddr_full = rd_y * i_in_w + rd_x;
    o_in_raddr = rd_en ? raddr_full[`BILIN_AW-1:0] : '0;
  end

  // ----------------------------------------
  // Walk control
  // ----------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= bilin_pkg::FETCH_IDLE;
      busy_r    <= 1'b0;
      cap_en    <= 1'b0;
      rd_cnt    <= '0;
      oy        <= '0;
      gx        <= '0;
      o_out_w   <= '0;
      o_out_h   <= '0;
      inv_scale <= '0;
    end else begin
      cap_en <= rd_en;
      if (i_walk_done) begin
        busy_r <= 1'b0;
      end
      case (state)
        bilin_pkg::FETCH_IDLE: begin
          if (start_ok) begin
            busy_r    <= 1'b1;
            o_out_w   <= mul_w[`BILIN_DIM_W+`BILIN_FRAC_W-1:`BILIN_FRAC_W];
            o_out_h   <= mul_h[`BILIN_DIM_W+`BILIN_FRAC_W-1:`BILIN_FRAC_W];
            inv_scale <= inv_next;
            state     <= bilin_pkg::FETCH_SETUP;
          end
        end
        bilin_pkg::FETCH_SETUP: begin
          oy <= '0;
          // Empty output image has nothing to write
          if (o_out_w == '0 || o_out_h == '0) begin
            busy_r <= 1'b0;
            state  <= bilin_pkg::FETCH_IDLE;
          end else begin
            state <= bilin_pkg::FETCH_ROW;
          end
        end
        bilin_pkg::FETCH_ROW: begin
          gx    <= '0;
          state <= bilin_pkg::FETCH_GROUP;
        end
        bilin_pkg::FETCH_GROUP: begin
          rd_cnt <= '0;
          state  <= bilin_pkg::FETCH_READ;
        end
        bilin_pkg::FETCH_READ: begin
          rd_cnt <= rd_cnt + 5'd1;
          if (rd_cnt[4]) begin
            state <= bilin_pkg::FETCH_HANDOFF;
          end
        end
        bilin_pkg::FETCH_HANDOFF: begin
          if (grp_xfer) begin
            if (gx + bilin_pkg::dim_t'(`BILIN_LANES) < o_out_w) begin
              gx    <= gx + bilin_pkg::dim_t'(`BILIN_LANES);
              state <= bilin_pkg::FETCH_GROUP;
            end else if (oy + 1'b1 < o_out_h) begin
              oy    <= oy + 1'b1;
              state <= bilin_pkg::FETCH_ROW;
            end else begin
              // Stay busy until the writer drains
              state <= bilin_pkg::FETCH_IDLE;
            end
          end
        end
        default: state <= bilin_pkg::FETCH_IDLE;
      endcase
    end
  end

  // ----------------------------------------
  // Coordinates and corner pixels
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (state == bilin_pkg::FETCH_ROW) begin
      {yi_base, fy_row} <= clamp_src(oy, inv_scale, i_in_h);
    end
    if (state == bilin_pkg::FETCH_GROUP) begin
      for (int l = 0; l < `BILIN_LANES; l++) begin
        {xi_base[l], o_lane_req[l].fx} <= clamp_src(lane_x[l], inv_scale, i_in_w);
        o_lane_req[l].x          <= lane_x[l];
        o_lane_req[l].lane_valid <= lane_x[l] < o_out_w;
        o_lane_req[l].fy         <= fy_row;
      end
    end
    if (cap_en) begin
      case (cap_idx[3:2])
        2'd0:    o_lane_req[cap_idx[1:0]].p00 <= i_in_rdata;
        2'd1:    o_lane_req[cap_idx[1:0]].p10 <= i_in_rdata;
        2'd2:    o_lane_req[cap_idx[1:0]].p01 <= i_in_rdata;
        default: o_lane_req[cap_idx[1:0]].p11 <= i_in_rdata;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hdl/bilin_lane.sv
`timescale 1ns/1ps
`default_nettype none

`include "bilin_params.svh"

module bilin_lane (
  input  wire logic                 clk,
  input  wire logic                 rst_n,
  input  wire logic                 i_valid,
  input  wire bilin_pkg::lane_req_t i_req,
  input  wire bilin_pkg::dim_t      i_row,
  input  wire logic                 i_ready,
  output logic                      o_ready,
  output logic                      o_valid,
  output bilin_pkg::pix_t           o_pix,
  output bilin_pkg::dim_t           o_x,
  output bilin_pkg::dim_t           o_row,
  output logic                      o_lane_valid
);

  bilin_pkg::weight_t wx0;
  bilin_pkg::weight_t wx1;
  bilin_pkg::weight_t wy0;
  bilin_pkg::weight_t wy1;
  bilin_pkg::weight_t w00;
  bilin_pkg::weight_t w10;
  bilin_pkg::weight_t w01;
  bilin_pkg::weight_t w11;
  bilin_pkg::acc_t    sum;
  logic               take;

  // Per-axis weights in Q0.8
  assign wx1 = bilin_pkg::weight_t'(i_req.fx);
  assign wx0 = bilin_pkg::weight_t'(`BILIN_ONE_Q08) - wx1;
  assign wy1 = bilin_pkg::weight_t'(i_req.fy);
  assign wy0 = bilin_pkg::weight_t'(`BILIN_ONE_Q08) - wy1;

  // Corner weights in Q0.16, at most 65536
  assign w00 = wx0 * wy0;
  assign w10 = wx1 * wy0;
  assign w01 = wx0 * wy1;
  assign w11 = wx1 * wy1;

  // Q8.16 sum plus half for rounding
  assign sum = w00 * i_req.p00 + w10 * i_req.p10 + w01 * i_req.p01 + w11 * i_req.p11
             + `BILIN_ROUND_Q016;

  // Free slot or the held result leaves this cycle
  assign o_ready = ~o_valid | i_ready;
  assign take    = i_valid & o_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_valid      <= 1'b0;
      o_lane_valid <= 1'b0;
    end else if (take) begin
      o_valid      <= 1'b1;
      o_lane_valid <= i_req.lane_valid;
    end else if (i_ready) begin
      o_valid <= 1'b0;
    end
  end

  // Held result
  always_ff @(posedge clk) begin
    if (take) begin
      o_pix <= sum[2*`BILIN_FRAC_W+`BILIN_PIX_W-1:2*`BILIN_FRAC_W];
      o_x   <= i_req.x;
      o_row <= i_row;
    end
  end

endmodule

`default_nettype wire

//--- hdl/bilin_writer.sv
`timescale 1ns/1ps
`default_nettype none

`include "bilin_params.svh"

module bilin_writer (
  input  wire logic             clk,
  input  wire logic             rst_n,
  input  wire logic             i_valid,
  input  wire bilin_pkg::pix_t  i_pix [`BILIN_LANES],
  input  wire bilin_pkg::dim_t  i_x [`BILIN_LANES],
  input  wire bilin_pkg::dim_t  i_row,
  input  wire logic             i_lane_valid [`BILIN_LANES],
  input  wire bilin_pkg::dim_t  i_out_w,
  input  wire bilin_pkg::dim_t  i_out_h,
  output logic                  o_ready,
  output bilin_pkg::addr_t      o_out_waddr,
  output bilin_pkg::pix_t       o_out_wdata,
  output logic                  o_out_we,
  output logic                  o_done
);

  logic [$clog2(`BILIN_LANES)-1:0] lane;
  logic [31:0]                     waddr_full;
  logic                            at_end;
  logic                            last_q;

  // Group is released on its last lane
  assign o_ready = (lane == ($clog2(`BILIN_LANES))'(`BILIN_LANES - 1));

  assign waddr_full = i_row * i_out_w + i_x[lane];

  // Bottom right pixel of the output image
  assign at_end = i_lane_valid[lane] && (i_x[lane] == i_out_w - 1'b1)
               && (i_row == i_out_h - 1'b1);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lane     <= '0;
      o_out_we <= 1'b0;
      last_q   <= 1'b0;
      o_done   <= 1'b0;
    end else begin
      // Padding lanes past the row end are skipped
      o_out_we <= i_valid && i_lane_valid[lane];
      last_q   <= i_valid && at_end;
      // Done trails the last write by one cycle
      o_done   <= last_q;
      if (i_valid) begin
        lane <= o_ready ? '0 : lane + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_valid) begin
      o_out_waddr <= waddr_full[`BILIN_AW-1:0];
      o_out_wdata <= i_pix[lane];
    end
  end

endmodule

`default_nettype wire

//--- hdl/bilin_scaler_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "bilin_params.svh"

module bilin_scaler_top (
  input  wire logic               clk,
  input  wire logic               rst_n,
  input  wire logic               i_start,
  output logic                    o_busy,
  output logic                    o_done,
  input  wire bilin_pkg::dim_t    i_in_w,
  input  wire bilin_pkg::dim_t    i_in_h,
  input  wire bilin_pkg::scale_t  i_scale_q88,
  output bilin_pkg::dim_t         o_out_w,
  output bilin_pkg::dim_t         o_out_h,
  output bilin_pkg::addr_t        o_in_raddr,
  input  wire bilin_pkg::pix_t    i_in_rdata,
  output bilin_pkg::addr_t        o_out_waddr,
  output bilin_pkg::pix_t         o_out_wdata,
  output logic                    o_out_we
);

  // Fetch to lanes
  bilin_pkg::lane_req_t lane_req [`BILIN_LANES];
  logic                 grp_valid;
  bilin_pkg::dim_t      grp_row;
  // Lanes run in lockstep so lane 0 speaks for the group
  logic                 lane_ready [`BILIN_LANES];
  logic                 lane_out_valid [`BILIN_LANES];
  bilin_pkg::pix_t      lane_pix [`BILIN_LANES];
  bilin_pkg::dim_t      lane_x [`BILIN_LANES];
  bilin_pkg::dim_t      lane_row [`BILIN_LANES];
  logic                 lane_flag [`BILIN_LANES];
  // Lanes to writer
  logic                 wr_ready;

  bilin_fetch u_fetch (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_start     (i_start),
    .i_in_w      (i_in_w),
    .i_in_h      (i_in_h),
    .i_scale_q88 (i_scale_q88),
    .i_in_rdata  (i_in_rdata),
    .i_grp_ready (lane_ready[0]),
    .i_walk_done (o_done),
    .o_busy      (o_busy),
    .o_out_w     (o_out_w),
    .o_out_h     (o_out_h),
    .o_in_raddr  (o_in_raddr),
    .o_grp_valid (grp_valid),
    .o_lane_req  (lane_req),
    .o_row       (grp_row)
  );

  for (genvar g = 0; g < `BILIN_LANES; g++) begin : g_lane
    bilin_lane u_lane (
      .clk          (clk),
      .rst_n        (rst_n),
      .i_valid      (grp_valid),
      .i_req        (lane_req[g]),
      .i_row        (grp_row),
      .i_ready      (wr_ready),
      .o_ready      (lane_ready[g]),
      .o_valid      (lane_out_valid[g]),
      .o_pix        (lane_pix[g]),
      .o_x          (lane_x[g]),
      .o_row        (lane_row[g]),
      .o_lane_valid (lane_flag[g])
    );
  end

  bilin_writer u_writer (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_valid      (lane_out_valid[0]),
    .i_pix        (lane_pix),
    .i_x          (lane_x),
    .i_row        (lane_row[0]),
    .i_lane_valid (lane_flag),
    .i_out_w      (o_out_w),
    .i_out_h      (o_out_h),
    .o_ready      (wr_ready),
    .o_out_waddr  (o_out_waddr),
    .o_out_wdata  (o_out_wdata),
    .o_out_we     (o_out_we),
    .o_done       (o_done)
  );

endmodule

`default_nettype wire

//--- tests/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic clk,
  output logic rst_n
);

  localparam int HALF_PERIOD  = 4;
  localparam int RESET_CYCLES = 8;

  // 8 ns period
  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  initial begin
    // Start high so the falling edge fires the async reset
    rst_n = 1'b1;
    #1 rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    // Release just after the edge like every other input
    #1 rst_n = 1'b1;
  end

endmodule

`default_nettype wire

//--- tests/bilin_properties.sv
`timescale 1ns/1ps
`default_nettype none

module bilin_properties (
  input wire logic clk,
  input wire logic rst_n,
  input wire logic i_busy,
  input wire logic i_done,
  input wire logic i_out_we
);

  // Failed assertions, summed into the closing count
  int fail_count = 0;

  // ----------------------------------------
  // Reset state
  // ----------------------------------------
  a_reset_quiet: assert property (
    @(posedge clk) !rst_n |-> (!i_busy && !i_done && !i_out_we)
  ) else begin
    fail_count++;
    $error("busy, done or write enable is high while reset is held");
  end

  // ----------------------------------------
  // Control outputs in operation
  // ----------------------------------------
  // No write outside a walk
  a_we_needs_busy: assert property (
    @(posedge clk) disable iff (!rst_n) i_out_we |-> i_busy
  ) else begin
    fail_count++;
    $error("write enable is high while the scaler is not busy");
  end

  // Done is a single-cycle pulse
  a_done_pulse: assert property (
    @(posedge clk) disable iff (!rst_n) i_done |=> !i_done
  ) else begin
    fail_count++;
    $error("done stayed high for more than one cycle");
  end

endmodule

`default_nettype wire

//--- tests/tb_bilin_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_bilin_top;

  localparam int MEM_DEPTH     = 4096;
  localparam int RESET_TIMEOUT = 64;
  localparam int BUSY_TIMEOUT  = 16;
  localparam int DONE_TIMEOUT  = 20000;

  logic              clk;
  logic              rst_n;
  logic              i_start;
  bilin_pkg::dim_t   i_in_w;
  bilin_pkg::dim_t   i_in_h;
  bilin_pkg::scale_t i_scale_q88;
  bilin_pkg::pix_t   i_in_rdata;
  logic              o_busy;
  logic              o_done;
  bilin_pkg::dim_t   o_out_w;
  bilin_pkg::dim_t   o_out_h;
  bilin_pkg::addr_t  o_in_raddr;
  bilin_pkg::addr_t  o_out_waddr;
  bilin_pkg::pix_t   o_out_wdata;
  logic              o_out_we;

  // Input image, captured output and per-address write counts
  bilin_pkg::pix_t   src_mem [MEM_DEPTH];
  bilin_pkg::pix_t   dst_mem [MEM_DEPTH];
  int                dst_hits [MEM_DEPTH];
  bilin_pkg::addr_t  rd_addr_q;
  integer            seed;
  int                errors;
  int                checks;
  int                out_pixels;
  logic              timed_out;

  tb_clk_gen u_clk (
    .clk   (clk),
    .rst_n (rst_n)
  );

  bilin_scaler_top dut0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_start     (i_start),
    .o_busy      (o_busy),
    .o_done      (o_done),
    .i_in_w      (i_in_w),
    .i_in_h      (i_in_h),
    .i_scale_q88 (i_scale_q88),
    .o_out_w     (o_out_w),
    .o_out_h     (o_out_h),
    .o_in_raddr  (o_in_raddr),
    .i_in_rdata  (i_in_rdata),
    .o_out_waddr (o_out_waddr),
    .o_out_wdata (o_out_wdata),
    .o_out_we    (o_out_we)
  );

  bind bilin_scaler_top bilin_properties u_props (
    .clk      (clk),
    .rst_n    (rst_n),
    .i_busy   (o_busy),
    .i_done   (o_done),
    .i_out_we (o_out_we)
  );

  // ----------------------------------------
  // Memory models
  // ----------------------------------------
  // Synchronous read with one cycle of latency
  always @(posedge clk) begin
    rd_addr_q = o_in_raddr;
    #1 i_in_rdata = src_mem[rd_addr_q];
  end

  // Write port capture, values are those held before the edge
  always @(posedge clk) begin
    if (rst_n && o_out_we) begin
      assert (o_out_waddr < out_pixels) begin
        dst_mem[o_out_waddr] = o_out_wdata;
        dst_hits[o_out_waddr]++;
      end else begin
        errors++;
        $display("ERROR: write to address 0x%h lies outside the output image", o_out_waddr);
      end
    end
  end

  // ----------------------------------------
  // Reference model
  // ----------------------------------------
  // Q16.8 source position split into base and fraction, pinned at the far border
  function automatic void map_source(input int pos, input int inv, input int size,
                                     output int base, output int frac);
    int q168;
    q168 = pos * inv;
    base = (q168 >> 8) & 'hffff;
    frac = q168 & 'hff;
    if (base >= size - 1) begin
      base = size - 2;
      frac = 255;
    end
  endfunction

  function automatic int expected_pixel(input int ox, input int oy, input int w,
                                        input int h, input int inv);
    int bx;
    int fx;
    int by;
    int fy;
    int row0;
    int row1;
    int acc;
    map_source(ox, inv, w, bx, fx);
    map_source(oy, inv, h, by, fy);
    row0 = by * w;
    row1 = (by + 1) * w;
    // Q0.16 corner weights times pixels, plus half for rounding
    acc = (256 - fx) * (256 - fy) * int'(src_mem[row0 + bx])
        + fx * (256 - fy) * int'(src_mem[row0 + bx + 1])
        + (256 - fx) * fy * int'(src_mem[row1 + bx])
        + fx * fy * int'(src_mem[row1 + bx + 1])
        + 32768;
    return (acc >> 16) & 'hff;
  endfunction

  // ----------------------------------------
  // Helpers
  // ----------------------------------------
  task automatic next_cycle;
    @(posedge clk);
    #1;
  endtask

  task automatic compare_value(input string name, input int got, input int exp);
    checks++;
    assert (got == exp) else begin
      errors++;
      $display("MISMATCH %s: got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic wait_busy(input int limit);
    int n;
    n = 0;
    while (o_busy !== 1'b1 && n < limit) begin
      next_cycle();
      n++;
    end
    if (o_busy !== 1'b1) begin
      timed_out = 1'b1;
      $display("ERROR: o_busy did not rise within %0d cycles of the start", limit);
    end
  endtask

  task automatic wait_done(input int limit);
    int n;
    n = 0;
    while (o_done !== 1'b1 && n < limit) begin
      next_cycle();
      n++;
    end
    if (o_done !== 1'b1) begin
      timed_out = 1'b1;
      $display("ERROR: o_done did not pulse within %0d cycles", limit);
    end
  endtask

  // One full image, optionally with a start pulse in the middle of the walk
  task automatic run_case(input int w, input int h, input int scale, input bit restart);
    int exp_w;
    int exp_h;
    int inv;
    int addr;
    exp_w = (w * scale) >> 8;
    exp_h = (h * scale) >> 8;
    inv   = (scale == 0) ? 'hffff : (65536 / scale) & 'hffff;
    out_pixels = exp_w * exp_h;
    for (int a = 0; a < MEM_DEPTH; a++) begin
      dst_mem[a]  = '0;
      dst_hits[a] = 0;
    end
    i_in_w      = bilin_pkg::dim_t'(w);
    i_in_h      = bilin_pkg::dim_t'(h);
    i_scale_q88 = bilin_pkg::scale_t'(scale);
    i_start     = 1'b1;
    next_cycle();
    i_start = 1'b0;
    wait_busy(BUSY_TIMEOUT);
    if (timed_out) return;
    compare_value("o_out_w", o_out_w, exp_w);
    compare_value("o_out_h", o_out_h, exp_h);
    if (restart) begin
      repeat (40) next_cycle();
      // Start while busy is ignored
      i_start = 1'b1;
      next_cycle();
      i_start = 1'b0;
    end
    wait_done(DONE_TIMEOUT);
    if (timed_out) return;
    compare_value("o_busy", o_busy, 0);
    // Every output pixel written once with the blended value
    for (int oy = 0; oy < exp_h; oy++) begin
      for (int ox = 0; ox < exp_w; ox++) begin
        addr = oy * exp_w + ox;
        checks++;
        assert (dst_hits[addr] == 1) else begin
          errors++;
          $display("ERROR: output address 0x%h written %0d times instead of once",
                   addr, dst_hits[addr]);
        end
        compare_value("o_out_wdata", dst_mem[addr], expected_pixel(ox, oy, w, h, inv));
      end
    end
    // Pulse is over and the scaler stays idle
    repeat (8) begin
      next_cycle();
      compare_value("o_done", o_done, 0);
      compare_value("o_busy", o_busy, 0);
    end
  endtask

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------
  initial begin
    int n;
    seed        = 13837;
    errors      = 0;
    checks      = 0;
    out_pixels  = 0;
    timed_out   = 1'b0;
    i_start     = 1'b0;
    i_in_w      = '0;
    i_in_h      = '0;
    i_scale_q88 = '0;
    i_in_rdata  = '0;
    for (int a = 0; a < MEM_DEPTH; a++) begin
      src_mem[a] = bilin_pkg::pix_t'($random(seed));
    end
    // Reset is applied shortly after time zero, then released
    n = 0;
    while (rst_n !== 1'b0 && n < RESET_TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (rst_n !== 1'b0) begin
      timed_out = 1'b1;
      $display("ERROR: reset was never asserted");
    end
    n = 0;
    while (rst_n !== 1'b1 && n < RESET_TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (rst_n !== 1'b1) begin
      timed_out = 1'b1;
      $display("ERROR: reset was never released");
    end
    next_cycle();
    // Scale 2.0 with a 14 pixel wide output, partial last group
    if (!timed_out) run_case(7, 4, 512, 1'b0);
    // Scale 1.5 with 13 pixel rows and a start pulse mid walk
    if (!timed_out) run_case(9, 6, 384, 1'b1);
    $display("checks %0d, errors %0d, assertion failures %0d, timeouts %0d",
             checks, errors, dut0.u_props.fail_count, timed_out);
    if (errors == 0 && dut0.u_props.fail_count == 0 && !timed_out) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
+incdir+hdl
hdl/bilin_pkg.sv
hdl/bilin_fetch.sv
hdl/bilin_lane.sv
hdl/bilin_writer.sv
hdl/bilin_scaler_top.sv
tests/tb_clk_gen.sv
tests/bilin_properties.sv
tests/tb_bilin_top.sv

//--- Bender.yml
package:
  name: bilin_scaler

export_include_dirs:
  - hdl

sources:
  - files:
      - hdl/bilin_pkg.sv
      - hdl/bilin_fetch.sv
      - hdl/bilin_lane.sv
      - hdl/bilin_writer.sv
      - hdl/bilin_scaler_top.sv
  - target: test
    files:
      - tests/tb_clk_gen.sv
      - tests/bilin_properties.sv
      - tests/tb_bilin_top.sv
